/* reg_host_defines.svh */
// Sizing and reset constants for the register host
// Queue depth must stay a power of two, the window is fixed at 64 bytes
`ifndef REG_HOST_DEFINES_SVH
`define REG_HOST_DEFINES_SVH

// Write requests held between acceptor and bank
`define RH_QUEUE_DEPTH 4

// Registers in the bank, one per 32-bit word of the window
`define RH_NUM_REGS 16

// Byte address of register 0
`define RH_WINDOW_BASE 32'h0000_1000

// Reset value of register 0, later registers add 0x100 each
`define RH_INIT_BASE 32'h1234_5678

`endif

/* reg_host_types_pkg.sv */
// Scalar types, response codes and FSM encodings of the register host
// Address and data are fixed at 32 bits
package reg_host_types_pkg;

    // Byte address from the host
    typedef logic [31:0] addr_t;

    // Register contents
    typedef logic [31:0] data_t;

    // Word index inside the register window
    typedef logic [3:0] reg_idx_t;

    // Write response code
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // Acceptor FSM
    typedef enum logic {
        ACC_IDLE,  // Ready while queue has room
        ACC_PUSH   // Captured pair goes into the queue
    } accept_state_t;

    // Register bank FSM
    typedef enum logic [1:0] {
        BANK_IDLE,  // Waiting for a queued request
        BANK_EXEC,  // Decode and write
        BANK_RESP   // Response pulse
    } bank_state_t;

endpackage

/* reg_host_bus_pkg.sv */
// Request and response records passed between the host blocks
// Field order sets the packed layout, address in the upper half
package reg_host_bus_pkg;

    // One accepted write, 64 bits
    typedef struct packed {
        reg_host_types_pkg::addr_t addr;
        reg_host_types_pkg::data_t data;
    } wr_req_t;

    // Answer to one write, 34 bits
    typedef struct packed {
        reg_host_types_pkg::data_t rdata;  // Previous register value
        reg_host_types_pkg::resp_t resp;
    } wr_rsp_t;

endpackage

/* write_accept.sv */
// Takes an address/data pair when both valid levels and ready are high
// At most one write every two cycles, ready stays low while the queue is full
`timescale 1ns/1ps

module write_accept (
    input  logic                        clk,
    input  logic                        rst,
    input  reg_host_types_pkg::addr_t   awaddr_i,
    input  reg_host_types_pkg::data_t   wdata_i,
    input  logic                        awvalid_i,
    input  logic                        wvalid_i,
    input  logic                        full_i,
    output logic                        awready_o,
    output logic                        wready_o,
    output logic                        push_o,
    output reg_host_bus_pkg::wr_req_t   req_o
);

    import reg_host_types_pkg::*;
    import reg_host_bus_pkg::*;

    accept_state_t state_q;
    logic          run_q;      // Low during reset and the edge after it
    wr_req_t       req_q;
    logic          ready;
    logic          accept;

    // Address and data ready are one shared level
    assign ready  = run_q && (state_q == ACC_IDLE) && !full_i;
    assign accept = ready && awvalid_i && wvalid_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ACC_IDLE;
            run_q   <= 1'b0;
        end else begin
            run_q <= 1'b1;
            case (state_q)
                ACC_IDLE: begin
                    if (accept) begin
                        state_q <= ACC_PUSH;
                    end
                end
                ACC_PUSH: begin
                    state_q <= ACC_IDLE;  // Single push per write
                end
                default: begin
                    state_q <= ACC_IDLE;
                end
            endcase
        end
    end

    // Captured pair is held until the push cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.addr <= awaddr_i;
            req_q.data <= wdata_i;
        end
    end

    assign awready_o = ready;
    assign wready_o  = ready;
    assign push_o    = (state_q == ACC_PUSH);
    assign req_o     = req_q;

    // Acceptance only with room, so the following push never meets a full queue
    a_no_push_full : assert property (
        @(posedge clk) disable iff (rst)
        push_o |-> !full_i
    ) else $error("write_accept: push while queue full");

endmodule

/* req_queue.sv */
// Show-ahead FIFO of write requests, head valid whenever empty_o is low
// Depth from RH_QUEUE_DEPTH, which must be a power of two
`timescale 1ns/1ps
`include "reg_host_defines.svh"

module req_queue (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push_i,
    input  reg_host_bus_pkg::wr_req_t   req_i,
    input  logic                        pop_i,
    output reg_host_bus_pkg::wr_req_t   head_o,
    output logic                        full_o,
    output logic                        empty_o
);

    import reg_host_bus_pkg::*;

    localparam int DEPTH = `RH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    wr_req_t          mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;    // One extra bit to tell full from empty

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at DEPTH
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    assign head_o  = mem_q[rd_ptr_q];  // Oldest entry
    assign full_o  = (count_q == (PTR_W + 1)'(DEPTH));
    assign empty_o = (count_q == '0);

    a_no_overflow : assert property (
        @(posedge clk) disable iff (rst)
        push_i |-> !full_o
    ) else $error("req_queue: push while full");

    a_no_underflow : assert property (
        @(posedge clk) disable iff (rst)
        pop_i |-> !empty_o
    ) else $error("req_queue: pop while empty");

endmodule

/* reg_bank.sv */
// Sixteen 32-bit registers written from the request queue, one write at a time
// Hits need the window base in addr[31:6] and a word-aligned address
`timescale 1ns/1ps
`include "reg_host_defines.svh"

module reg_bank (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        empty_i,
    input  reg_host_bus_pkg::wr_req_t   head_i,
    output logic                        pop_o,
    output logic                        rsp_valid_o,
    output reg_host_bus_pkg::wr_rsp_t   rsp_o
);

    import reg_host_types_pkg::*;
    import reg_host_bus_pkg::*;

    localparam addr_t WIN_BASE  = `RH_WINDOW_BASE;
    localparam data_t INIT_BASE = `RH_INIT_BASE;
    localparam data_t INIT_STEP = 32'h0000_0100;  // Reset value spacing

    bank_state_t state_q;
    wr_req_t     req_q;        // Request being executed
    wr_rsp_t     rsp_q;
    data_t       regs_q [`RH_NUM_REGS];
    reg_idx_t    idx;
    logic        hit;

    // Decode
    assign idx = req_q.addr[5:2];
    assign hit = (req_q.addr[31:6] == WIN_BASE[31:6]) && (req_q.addr[1:0] == 2'b00);

    assign pop_o = (state_q == BANK_IDLE) && !empty_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= BANK_IDLE;
        end else begin
            case (state_q)
                BANK_IDLE: begin
                    if (pop_o) begin
                        state_q <= BANK_EXEC;
                    end
                end
                BANK_EXEC: begin
                    state_q <= BANK_RESP;
                end
                BANK_RESP: begin
                    state_q <= BANK_IDLE;  // Responses cannot stall
                end
                default: begin
                    state_q <= BANK_IDLE;
                end
            endcase
        end
    end

    // Head is latched on the pop edge
    always_ff @(posedge clk) begin
        if (pop_o) begin
            req_q <= head_i;
        end
    end

    // Register file, reset to the pattern values
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RH_NUM_REGS; i++) begin
                regs_q[i] <= INIT_BASE + data_t'(i) * INIT_STEP;
            end
        end else if ((state_q == BANK_EXEC) && hit) begin
            regs_q[idx] <= req_q.data;
        end
    end

    // Old value read in the same cycle as the write
    always_ff @(posedge clk) begin
        if (state_q == BANK_EXEC) begin
            if (hit) begin
                rsp_q.rdata <= regs_q[idx];
                rsp_q.resp  <= RESP_OKAY;
            end else begin
                rsp_q.rdata <= '0;           // Nothing leaks on errors
                rsp_q.resp  <= RESP_SLVERR;
            end
        end
    end

    assign rsp_valid_o = (state_q == BANK_RESP);
    assign rsp_o       = rsp_q;

    a_rsp_pulse : assert property (
        @(posedge clk) disable iff (rst)
        rsp_valid_o |=> !rsp_valid_o
    ) else $error("reg_bank: response valid longer than one cycle");

endmodule

/* reg_host_top.sv */
// Write host for the register bank: acceptor, request queue, bank
// Responses arrive in acceptance order and cannot be held off
`timescale 1ns/1ps

module reg_host_top (
    input  logic                        clk,
    input  logic                        rst,
    input  reg_host_types_pkg::addr_t   awaddr_i,
    input  reg_host_types_pkg::data_t   wdata_i,
    input  logic                        awvalid_i,
    input  logic                        wvalid_i,
    output logic                        awready_o,
    output logic                        wready_o,
    output logic                        rsp_valid_o,
    output reg_host_bus_pkg::wr_rsp_t   rsp_o
);

    import reg_host_bus_pkg::*;

    logic    push;
    logic    pop;
    logic    full;
    logic    empty;
    wr_req_t push_req;   // Acceptor to queue
    wr_req_t head_req;   // Queue to bank

    write_accept u_accept (
        .clk       (clk),
        .rst       (rst),
        .awaddr_i  (awaddr_i),
        .wdata_i   (wdata_i),
        .awvalid_i (awvalid_i),
        .wvalid_i  (wvalid_i),
        .full_i    (full),
        .awready_o (awready_o),
        .wready_o  (wready_o),
        .push_o    (push),
        .req_o     (push_req)
    );

    req_queue u_queue (
        .clk     (clk),
        .rst     (rst),
        .push_i  (push),
        .req_i   (push_req),
        .pop_i   (pop),
        .head_o  (head_req),
        .full_o  (full),
        .empty_o (empty)
    );

    reg_bank u_bank (
        .clk         (clk),
        .rst         (rst),
        .empty_i     (empty),
        .head_i      (head_req),
        .pop_o       (pop),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

endmodule

/* tb_reg_host.sv */
// Table-driven testbench for reg_host_top with an in-order reference model
// Stops at the first error, each table entry is allowed about 20 cycles
`timescale 1ns/1ps
`include "reg_host_defines.svh"

module tb_reg_host;

    import reg_host_types_pkg::*;
    import reg_host_bus_pkg::*;

    localparam int    NUM_ENTRIES = 44;
    localparam int    MAX_CYCLES  = NUM_ENTRIES * 20 + 100;
    localparam addr_t WIN_BASE    = `RH_WINDOW_BASE;
    localparam addr_t WIN_BYTES   = 32'd64;

    // One row of the stimulus table
    typedef struct packed {
        addr_t      addr;
        data_t      data;
        logic [3:0] gap;   // Idle cycles after acceptance
        resp_t      resp;  // Expected response code
    } entry_t;

    logic    clk;
    logic    rst;
    addr_t   awaddr_i;
    data_t   wdata_i;
    logic    awvalid_i;
    logic    wvalid_i;
    logic    awready_o;
    logic    wready_o;
    logic    rsp_valid_o;
    wr_rsp_t rsp_o;

    entry_t  tbl [NUM_ENTRIES];
    int      n_fill;
    int      cur_idx;
    int      seed;
    data_t   model_regs [`RH_NUM_REGS];
    wr_rsp_t exp_q [$];     // Expected responses in acceptance order
    int      cycles = 0;
    logic    active;        // Monitor runs once reset checks are done
    logic    stall_seen;    // Ready held low by a full queue
    string   reason;

    reg_host_top dut (
        .clk         (clk),
        .rst         (rst),
        .awaddr_i    (awaddr_i),
        .wdata_i     (wdata_i),
        .awvalid_i   (awvalid_i),
        .wvalid_i    (wvalid_i),
        .awready_o   (awready_o),
        .wready_o    (wready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    always #50 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input resp_t got, input resp_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // 64-byte window, word aligned
    function automatic logic in_window(input addr_t a);
        return (a >= WIN_BASE) && (a < WIN_BASE + WIN_BYTES) && (a[1:0] == 2'b00);
    endfunction

    task automatic model_accept(input addr_t a, input data_t d, input resp_t exp_resp);
        wr_rsp_t  e;
        reg_idx_t idx;
        logic     hit;
        hit = in_window(a);
        idx = reg_idx_t'((a - WIN_BASE) >> 2);
        if (hit != (exp_resp == RESP_OKAY)) begin
            stop_run($sformatf("table entry %0d disagrees with the window rule", cur_idx));
        end
        if (hit) begin
            e.rdata = model_regs[idx];
            e.resp  = RESP_OKAY;
            model_regs[idx] = d;
        end else begin
            e.rdata = '0;
            e.resp  = RESP_SLVERR;
        end
        exp_q.push_back(e);
    endtask

    task automatic add_entry(input addr_t a, input data_t d, input int gap, input resp_t r);
        tbl[n_fill] = '{a, d, 4'(gap), r};
        n_fill++;
    endtask

    task automatic fill_table();
        int r;
        n_fill = 0;
        // First write to every register, queue idle in between
        for (int i = 0; i < 16; i++) begin
            add_entry(WIN_BASE + 4 * i, data_t'($random(seed)), 4, RESP_OKAY);
        end
        for (int i = 0; i < 16; i += 5) begin  // Registers 0, 5, 10, 15 again
            add_entry(WIN_BASE + 4 * i, data_t'($random(seed)), 2, RESP_OKAY);
        end
        // Misses, each one aimed near a real register
        add_entry(WIN_BASE + WIN_BYTES, data_t'($random(seed)), 2, RESP_SLVERR);
        add_entry(WIN_BASE - 32'd4, data_t'($random(seed)), 2, RESP_SLVERR);
        add_entry(WIN_BASE + 32'h6, data_t'($random(seed)), 2, RESP_SLVERR);  // Misaligned
        add_entry(WIN_BASE + 32'h9, data_t'($random(seed)), 2, RESP_SLVERR);
        add_entry(WIN_BASE, data_t'($random(seed)), 2, RESP_OKAY);
        add_entry(WIN_BASE + 32'h3c, data_t'($random(seed)), 2, RESP_OKAY);
        add_entry(WIN_BASE + 32'h4, data_t'($random(seed)), 2, RESP_OKAY);
        add_entry(WIN_BASE + 32'h8, data_t'($random(seed)), 2, RESP_OKAY);
        // Back-to-back burst that fills the queue
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            if (i % 5 == 4) begin
                add_entry(32'h0000_2000 + 4 * i, data_t'($random(seed)), 0, RESP_SLVERR);
            end else begin
                add_entry(WIN_BASE + 4 * (r & 15), data_t'($random(seed)), 0, RESP_OKAY);
            end
        end
        if (n_fill != NUM_ENTRIES) begin
            stop_run("stimulus table has the wrong number of entries");
        end
    endtask

    // Hold valid until ready is seen, then release and wait out the gap
    task automatic apply_entry(input int i);
        int   low_run;
        logic taken;
        low_run   = 0;
        taken     = 1'b0;
        cur_idx   = i;
        awaddr_i  = tbl[i].addr;
        wdata_i   = tbl[i].data;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        while (!taken) begin
            @(negedge clk);
            if (awready_o) begin
                taken = 1'b1;
            end else begin
                low_run++;
                if (low_run >= 2) begin
                    stall_seen = 1'b1;  // Longer than the push cycle
                end
            end
        end
        @(posedge clk);
        #1;
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        repeat (tbl[i].gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(negedge clk) begin : monitor
        wr_rsp_t exp_rsp;
        if (active) begin
            check_level("wready_o", wready_o, awready_o);
            if (rsp_valid_o) begin
                if (exp_q.size() == 0) begin
                    stop_run("response arrived with no write outstanding");
                end else begin
                    exp_rsp = exp_q.pop_front();
                    check_data("rsp_o.rdata", rsp_o.rdata, exp_rsp.rdata);
                    check_resp("rsp_o.resp", rsp_o.resp, exp_rsp.resp);
                end
            end
            if (awvalid_i && wvalid_i && awready_o) begin  // Taken on the next edge
                model_accept(awaddr_i, wdata_i, tbl[cur_idx].resp);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            stop_run($sformatf("timeout: %0d writes still unanswered after %0d cycles",
                               exp_q.size(), cycles));
        end
    end

    initial begin
        seed       = 7366;
        clk        = 1'b0;
        rst        = 1'b1;
        awaddr_i   = '0;
        wdata_i    = '0;
        awvalid_i  = 1'b0;
        wvalid_i   = 1'b0;
        active     = 1'b0;
        stall_seen = 1'b0;
        cur_idx    = 0;
        reason     = "";
        for (int i = 0; i < `RH_NUM_REGS; i++) begin
            model_regs[i] = data_t'(`RH_INIT_BASE) + data_t'(i << 8);
        end
        fill_table();

        // Outputs stay quiet through reset and the first edge after it
        repeat (8) begin
            @(negedge clk);
            check_level("awready_o", awready_o, 1'b0);
            check_level("wready_o", wready_o, 1'b0);
            check_level("rsp_valid_o", rsp_valid_o, 1'b0);
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_level("awready_o", awready_o, 1'b0);
        check_level("wready_o", wready_o, 1'b0);
        check_level("rsp_valid_o", rsp_valid_o, 1'b0);
        @(negedge clk);
        check_level("awready_o", awready_o, 1'b1);
        check_level("wready_o", wready_o, 1'b1);
        active = 1'b1;

        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            apply_entry(i);
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (6) begin  // A stray response would show up here
            @(negedge clk);
        end

        if (!stall_seen) begin
            reason = "queue never filled during the burst";
        end
        if (reason.len() != 0) begin
            stop_run(reason);
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

/* reg_host_top.f */
+incdir+.
reg_host_types_pkg.sv
reg_host_bus_pkg.sv
write_accept.sv
req_queue.sv
reg_bank.sv
reg_host_top.sv
tb_reg_host.sv

/* Makefile */
# Verilator build and run of the register host testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_reg_host
FILELIST  ?= reg_host_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard *.sv) $(wildcard *.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "FAIL, see $(LOG)"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || { echo "FAIL, no result in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
